// File: verification/ex_mem_cases.txt
# name aluop porta portb imm pcn br_kind memtoreg regwrite memread memwrite halt dest
# then expected retire_data retire_dest retire_regwrite; every field after the name is hex
add_basic 0 00000005 00000007 00000000 00000104 0 0 1 0 0 0 01 0000000c 01 1
sub_neg 1 00000003 00000005 00000000 00000108 0 0 1 0 0 0 02 fffffffe 02 1
and_mask 2 f0f0f0f0 ff00ff00 00000000 0000010c 0 0 1 0 0 0 03 f000f000 03 1
or_merge 3 f0f0f0f0 0f000000 00000000 00000110 0 0 1 0 0 0 04 fff0f0f0 04 1
xor_flip 4 aaaa5555 ffff0000 00000000 00000114 0 0 1 0 0 0 05 55555555 05 1
nor_bits 5 0000ffff 00ff0000 00000000 00000118 0 0 1 0 0 0 06 ff000000 06 1
sll_low5 6 00000024 00000001 00000000 0000011c 0 0 1 0 0 0 07 00000010 07 1
sll_wrap 6 0000003f 00000003 00000000 00000120 0 0 1 0 0 0 08 80000000 08 1
srl_low5 7 00000023 80000000 00000000 00000124 0 0 1 0 0 0 09 10000000 09 1
slt_signed 8 ffffffff 00000001 00000000 00000128 0 0 1 0 0 0 0a 00000001 0a 1
sltu_unsigned 9 ffffffff 00000001 00000000 0000012c 0 0 1 0 0 0 0b 00000000 0b 1
slt_minint 8 00000001 80000000 00000000 00000130 0 0 1 0 0 0 0c 00000000 0c 1
sltu_true 9 00000001 80000000 00000000 00000134 0 0 1 0 0 0 0d 00000001 0d 1
sw_word 0 00000100 deadbeef 00000010 00000138 0 0 0 0 1 0 00 00000110 00 0
lw_word 0 00000108 00000000 00000008 0000013c 0 1 1 1 0 0 0e deadbeef 0e 1
lw_fill 0 00000080 00000000 00000000 00000140 0 1 1 1 0 0 0f c0de0020 0f 1
sw_neg_off 0 00000200 12345678 fffffffc 00000144 0 0 0 0 1 0 00 000001fc 00 0
lw_neg_off 0 000001f0 00000000 0000000c 00000148 0 1 1 1 0 0 10 12345678 10 1
beq_taken 1 00000009 00000009 00000004 0000014c 1 0 0 0 0 0 00 00000000 00 0
sw_squashed 0 00000100 bad0bad0 00000010 00000150 0 0 0 0 1 0 00 00000000 00 0
lw_after_squash 0 00000100 00000000 00000010 00000154 0 1 1 1 0 0 11 deadbeef 11 1
bne_taken 1 00000001 00000002 fffffffe 00000158 2 0 0 0 0 0 00 ffffffff 00 0
add_squashed 0 00000001 00000001 00000000 0000015c 0 0 1 0 0 0 12 00000000 12 0
beq_untaken 1 00000003 00000004 00000002 00000160 1 0 0 0 0 0 00 ffffffff 00 0
add_after_untaken 0 00000010 00000020 00000000 00000164 0 0 1 0 0 0 13 00000030 13 1
bne_untaken 1 00000005 00000005 00000003 00000168 2 0 0 0 0 0 00 00000000 00 0
jal_link 0 00000000 00000000 00000020 0000016c 3 2 1 0 0 0 1f 0000016c 1f 1
halt_squashed 0 00000000 00000000 00000000 00000170 0 0 0 0 0 1 00 00000000 00 0
or_after_jump 3 00000001 00000002 00000000 00000174 0 0 1 0 0 0 14 00000003 14 1
halt_final 0 00000000 00000000 00000000 00000178 0 0 0 0 0 1 00 00000000 00 0

// File: sources.f
+incdir+include
source/cpu_types_pkg.sv
source/pipe_ctrl_pkg.sv
source/pipereg_ex_mem_if.sv
source/alu_unit.sv
source/branch_resolve.sv
source/pl_ex_mem.sv
source/mem_access.sv
source/ex_mem_top.sv
verification/ex_mem_tb.sv

// File: verification/ex_mem_tb.sv
`timescale 1ns/1ps

module ex_mem_tb;
   import cpu_types_pkg::*;
   import pipe_ctrl_pkg::*;

   localparam int RESET_CYCLES = 4;
   localparam int MAX_CASES = 64;
   // field positions within a case record, after the name
   localparam int OP = 0, RA = 1, RB = 2, IMM = 3, PCN = 4, BR = 5, MTR = 6, RW = 7,
                  RD = 8, WR = 9, HALT = 10, DEST = 11, EDATA = 12, EDEST = 13, ERW = 14;

   logic       CLK;
   logic       nRST;
   aluop_t     aluop;
   word_t      porta, portb, imm, pcn;
   branch_t    br_kind;
   memtoreg_t  memtoreg;
   logic       regwrite, memread, memwrite, halt;
   regbits_t   dest;
   logic       ex_ready, branch_taken, cyc, stb, we, ack;
   word_t      branch_target, adr, wdata, rdata, retire_data;
   logic [3:0] sel;
   logic       retire_valid, retire_regwrite, retire_halt;
   regbits_t   retire_dest;

   string       case_name [MAX_CASES];
   logic [31:0] fld [MAX_CASES][15];
   word_t       mem_words [256]; // word addressed by adr[9:2]
   int          n_cases, retired, errors, bus_count, bus_expected, waits, seed_val;
   logic        cases_loaded, squash_next, in_cycle;
   int          exp_q[$];
   logic        sq_q[$];
   int          bus_q[$];

   ex_mem_top dut (.*);

   initial begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;
   end

   task automatic load_cases();
      int    fd;
      int    cnt;
      string line;
      n_cases = 0;
      fd = $fopen("verification/ex_mem_cases.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("error: cannot open verification/ex_mem_cases.txt");
      end else begin
         while (!$feof(fd) && n_cases < MAX_CASES) begin
            cnt = $fgets(line, fd);
            if (cnt > 0 && line[0] != "#") begin
               cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  case_name[n_cases], fld[n_cases][0], fld[n_cases][1], fld[n_cases][2],
                  fld[n_cases][3], fld[n_cases][4], fld[n_cases][5], fld[n_cases][6],
                  fld[n_cases][7], fld[n_cases][8], fld[n_cases][9], fld[n_cases][10],
                  fld[n_cases][11], fld[n_cases][12], fld[n_cases][13], fld[n_cases][14]);
               if (cnt == 16) begin
                  n_cases++;
               end else if (cnt > 0) begin
                  errors++;
                  $display("error: malformed line in case file: %s", line);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic drive_case(input int i);
      aluop = aluop_t'(fld[i][OP][3:0]);
      porta = fld[i][RA];
      portb = fld[i][RB];
      imm = fld[i][IMM];
      pcn = fld[i][PCN];
      br_kind = branch_t'(fld[i][BR][1:0]);
      memtoreg = memtoreg_t'(fld[i][MTR][1:0]);
      regwrite = fld[i][RW][0];
      memread = fld[i][RD][0];
      memwrite = fld[i][WR][0];
      halt = fld[i][HALT][0];
      dest = fld[i][DEST][4:0];
   endtask

   // hold the case until ex_ready, check the redirect, queue the retire
   task automatic present_case(input int i);
      logic  cond;
      logic  exp_taken;
      word_t exp_target;
      drive_case(i);
      @(negedge CLK);
      while (!ex_ready) begin
         @(negedge CLK);
      end
      case (fld[i][BR][1:0])
         2'd1: cond = (porta == portb);
         2'd2: cond = (porta != portb);
         2'd3: cond = 1'b1;
         default: cond = 1'b0;
      endcase
      exp_taken = cond && !squash_next; // wrong-path branch
      exp_target = fld[i][PCN] + {fld[i][IMM][29:0], 2'b00}; // word offset
      if (branch_taken !== exp_taken) begin
         errors++;
         $display("mismatch %s branch_taken: expected %0b, actual %0b",
            case_name[i], exp_taken, branch_taken);
      end
      if (exp_taken && branch_target !== exp_target) begin
         errors++;
         $display("mismatch %s branch_target: expected %h, actual %h",
            case_name[i], exp_target, branch_target);
      end
      exp_q.push_back(i);
      sq_q.push_back(squash_next);
      if ((memread || memwrite) && !squash_next) begin
         bus_q.push_back(i);
         bus_expected++;
      end
      squash_next = exp_taken;
      @(posedge CLK);
      #1;
   endtask

   task automatic check_retire();
      int   i;
      logic sq;
      logic exp_rw;
      logic exp_halt;
      if (exp_q.size() == 0) begin
         errors++;
         $display("error: retire at %0t with no instruction outstanding", $time);
      end else begin
         i = exp_q.pop_front();
         sq = sq_q.pop_front();
         exp_rw = fld[i][ERW][0] && !sq;
         exp_halt = fld[i][HALT][0] && !sq;
         if (retire_regwrite !== exp_rw) begin
            errors++;
            $display("mismatch %s retire_regwrite: expected %0b, actual %0b",
               case_name[i], exp_rw, retire_regwrite);
         end
         if (retire_halt !== exp_halt) begin
            errors++;
            $display("mismatch %s retire_halt: expected %0b, actual %0b",
               case_name[i], exp_halt, retire_halt);
         end
         if (!sq && retire_data !== fld[i][EDATA]) begin
            errors++;
            $display("mismatch %s retire_data: expected %h, actual %h",
               case_name[i], fld[i][EDATA], retire_data);
         end
         if (!sq && retire_dest !== fld[i][EDEST][4:0]) begin
            errors++;
            $display("mismatch %s retire_dest: expected %h, actual %h",
               case_name[i], fld[i][EDEST][4:0], retire_dest);
         end
         retired++;
      end
   endtask

   task automatic serve_bus();
      int i;
      ack = 1'b1;
      bus_count++;
      if (bus_q.size() == 0) begin
         errors++;
         $display("error: bus cycle at %0t with no memory instruction outstanding", $time);
      end else begin
         i = bus_q.pop_front();
         if (adr !== fld[i][RA] + fld[i][IMM] || we !== fld[i][WR][0] || sel !== 4'hf) begin
            errors++;
            $display("mismatch %s bus adr/we/sel: expected %h/%0b/f, actual %h/%0b/%h",
               case_name[i], fld[i][RA] + fld[i][IMM], fld[i][WR][0], adr, we, sel);
         end
      end
      if (we) begin
         mem_words[adr[9:2]] = wdata;
      end else begin
         rdata = mem_words[adr[9:2]];
      end
   endtask

   // wishbone slave with 0 to 3 wait states
   initial begin
      ack = 1'b0;
      rdata = '0;
      in_cycle = 1'b0;
      for (int k = 0; k < 256; k++) begin
         mem_words[k] = 32'hc0de_0000 | k;
      end
      forever begin
         @(posedge CLK);
         #1;
         if (ack) begin
            ack = 1'b0;
            in_cycle = 1'b0;
         end else if (cyc && stb) begin
            if (!in_cycle) begin
               in_cycle = 1'b1;
               waits = $urandom % 4;
            end
            if (waits == 0) begin
               serve_bus();
            end else begin
               waits--;
            end
         end
      end
   end

   always @(negedge CLK) begin
      if (nRST && retire_valid) begin
         check_retire();
      end
   end

   initial begin
      wait (cases_loaded === 1'b1);
      repeat (n_cases * 10 + RESET_CYCLES) @(posedge CLK);
      $display("error: timeout, %0d of %0d instructions retired", retired, n_cases);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      seed_val = $urandom(32'h46ee3fb4);
      nRST = 1'b0;
      aluop = ALU_ADD;
      br_kind = BR_NONE;
      memtoreg = MTR_ALU;
      {porta, portb, imm, pcn} = '0;
      {regwrite, memread, memwrite, halt} = '0;
      dest = '0;
      {errors, retired, bus_count, bus_expected} = '0;
      squash_next = 1'b0;
      cases_loaded = 1'b0;
      load_cases();
      cases_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge CLK);
      #1;
      if (retire_valid !== 1'b0 || cyc !== 1'b0 || stb !== 1'b0 || ex_ready !== 1'b1) begin
         errors++;
         $display("error: outputs not idle after reset (retire_valid %b cyc %b stb %b ready %b)",
            retire_valid, cyc, stb, ex_ready);
      end
      nRST = 1'b1;
      if (n_cases == 0) begin
         errors++;
         $display("error: no test cases read");
      end else begin
         for (int i = 0; i < n_cases; i++) begin
            present_case(i);
         end
         wait (retired == n_cases);
      end
      if (bus_count != bus_expected) begin
         errors++;
         $display("mismatch wishbone_cycles: expected %0d, actual %0d", bus_expected, bus_count);
      end
      $display("done: %0d cases, %0d retired, %0d bus cycles, %0d errors",
         n_cases, retired, bus_count, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: source/ex_mem_top.sv
`timescale 1ns/1ps

module ex_mem_top (
   input  logic                      CLK,
   input  logic                      nRST,
   input  cpu_types_pkg::aluop_t     aluop,
   input  cpu_types_pkg::word_t      porta,
   input  cpu_types_pkg::word_t      portb,
   input  cpu_types_pkg::word_t      imm,
   input  cpu_types_pkg::word_t      pcn,
   input  pipe_ctrl_pkg::branch_t    br_kind,
   input  pipe_ctrl_pkg::memtoreg_t  memtoreg,
   input  logic                      regwrite,
   input  logic                      memread,
   input  logic                      memwrite,
   input  logic                      halt,
   input  cpu_types_pkg::regbits_t   dest,
   output logic                      ex_ready,
   output logic                      branch_taken,
   output cpu_types_pkg::word_t      branch_target,
   output logic                      cyc,
   output logic                      stb,
   output logic                      we,
   output cpu_types_pkg::word_t      adr,
   output cpu_types_pkg::word_t      wdata,
   output logic [3:0]                sel,
   input  cpu_types_pkg::word_t      rdata,
   input  logic                      ack,
   output logic                      retire_valid,
   output logic                      retire_regwrite,
   output logic                      retire_halt,
   output cpu_types_pkg::regbits_t   retire_dest,
   output cpu_types_pkg::word_t      retire_data
);
   import cpu_types_pkg::*;

   word_t alu_b;
   logic  entry_valid;

   pipereg_ex_mem_if exm ();

   // loads and stores address off base plus offset, portb is the store data
   assign alu_b = (memread || memwrite) ? imm : portb;

   assign exm.wb_memtoreg_in = memtoreg;
   assign exm.wb_regwrite_in = regwrite;
   assign exm.m_memread_in = memread;
   assign exm.m_memwrite_in = memwrite;
   assign exm.regfile_rdat2_in = portb;
   assign exm.reg_instr_in = dest;
   assign exm.halt_in = halt;
   assign exm.pcn_in = pcn;
   assign exm.adder_result_in = branch_target;
   assign exm.m_branch_in = branch_taken;

   alu_unit u_alu (
      .aluop  (aluop),
      .porta  (porta),
      .portb  (alu_b),
      .result (exm.alu_output_in),
      .zero   (exm.alu_zero_in)
   );

   branch_resolve u_branch (
      .CLK     (CLK),
      .nRST    (nRST),
      .accept  (ex_ready),
      .br_kind (br_kind),
      .rs_val  (porta),
      .rt_val  (portb),
      .pcn     (pcn),
      .imm     (imm),
      .taken   (branch_taken),
      .target  (branch_target),
      .sq      (exm.squash)
   );

   pl_ex_mem u_ex_mem (
      .CLK         (CLK),
      .nRST        (nRST),
      .xmem        (exm.xmem),
      .entry_valid (entry_valid)
   );

   mem_access u_mem (
      .CLK             (CLK),
      .nRST            (nRST),
      .mem             (exm.mem),
      .entry_valid     (entry_valid),
      .ex_ready        (ex_ready),
      .cyc             (cyc),
      .stb             (stb),
      .we              (we),
      .adr             (adr),
      .wdata           (wdata),
      .sel             (sel),
      .rdata           (rdata),
      .ack             (ack),
      .retire_valid    (retire_valid),
      .retire_regwrite (retire_regwrite),
      .retire_halt     (retire_halt),
      .retire_dest     (retire_dest),
      .retire_data     (retire_data)
   );

endmodule

// File: source/mem_access.sv
`timescale 1ns/1ps

module mem_access (
   input  logic                    CLK,
   input  logic                    nRST,
   pipereg_ex_mem_if.mem           mem,
   input  logic                    entry_valid,
   output logic                    ex_ready,
   output logic                    cyc,
   output logic                    stb,
   output logic                    we,
   output cpu_types_pkg::word_t    adr,
   output cpu_types_pkg::word_t    wdata,
   output logic [3:0]              sel,
   input  cpu_types_pkg::word_t    rdata,
   input  logic                    ack,
   output logic                    retire_valid,
   output logic                    retire_regwrite,
   output logic                    retire_halt,
   output cpu_types_pkg::regbits_t retire_dest,
   output cpu_types_pkg::word_t    retire_data
);
   import cpu_types_pkg::*;
   import pipe_ctrl_pkg::*;

   mem_state_t state;
   logic       bubble_q; // reset entry, never retires
   logic       consumed; // bus access already served for this entry
   logic       is_mem;
   logic       issue;
   word_t      load_q;

   assign is_mem = entry_valid && (mem.m_memread_out || mem.m_memwrite_out);
   assign issue = (state == MEM_IDLE) && is_mem && !consumed && !bubble_q;

   // classic cycle held stable by the stalled register
   assign cyc = issue || (state == MEM_BUSY);
   assign stb = cyc;
   assign we = cyc && mem.m_memwrite_out;
   assign adr = mem.alu_output_out;
   assign wdata = mem.regfile_rdat2_out;
   assign sel = 4'hf; // word accesses only

   assign ex_ready = !cyc;
   assign mem.WEN = ex_ready;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state <= MEM_IDLE;
         bubble_q <= 1'b1;
         consumed <= 1'b0;
      end else begin
         if (mem.WEN) begin
            bubble_q <= 1'b0; // next entry loads on this edge
            consumed <= 1'b0;
         end
         case (state)
            MEM_IDLE: begin
               if (issue && ack) begin
                  consumed <= 1'b1; // zero wait states
               end else if (issue) begin
                  state <= MEM_BUSY;
               end
            end
            MEM_BUSY: begin
               if (ack) begin
                  state <= MEM_IDLE;
                  consumed <= 1'b1;
               end
            end
            default: state <= MEM_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (cyc && ack) begin
         load_q <= rdata;
      end
   end

   assign retire_valid = ex_ready && !bubble_q;
   assign retire_regwrite = retire_valid && entry_valid && mem.wb_regwrite_out;
   assign retire_halt = retire_valid && entry_valid && mem.halt_out;
   assign retire_dest = mem.reg_instr_out;

   always_comb begin
      case (mem.wb_memtoreg_out)
         MTR_MEM:  retire_data = load_q;
         MTR_LINK: retire_data = mem.pcn_out;
         default:  retire_data = mem.alu_output_out;
      endcase
   end

   // request stays put until the slave answers
   stb_held: assert property (
      @(posedge CLK) disable iff (!nRST)
         (cyc && !ack) |=> (stb && $stable(adr) && $stable(we) && $stable(wdata))
   ) else $error("mem_access: bus request changed before ack");

endmodule

// File: source/pl_ex_mem.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module pl_ex_mem (
   input  logic           CLK,
   input  logic           nRST,
   pipereg_ex_mem_if.xmem xmem,
   output logic           entry_valid
);
   import pipe_ctrl_pkg::*;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         xmem.wb_memtoreg_out <= MTR_ALU;
         xmem.wb_regwrite_out <= 1'b0;
         xmem.m_branch_out <= 1'b0;
         xmem.m_memread_out <= 1'b0;
         xmem.m_memwrite_out <= 1'b0;
         xmem.alu_zero_out <= 1'b0;
         xmem.alu_output_out <= '0;
         xmem.adder_result_out <= '0;
         xmem.regfile_rdat2_out <= '0;
         xmem.reg_instr_out <= '0;
         xmem.halt_out <= 1'b0;
         xmem.pcn_out <= `RESET_PC;
         entry_valid <= 1'b0; // empty register reads as a bubble
      end else if (xmem.flush) begin
         // squash, no memory request and nothing to write back
         xmem.m_memread_out <= 1'b0;
         xmem.m_memwrite_out <= 1'b0;
         xmem.wb_regwrite_out <= 1'b0;
         xmem.halt_out <= 1'b0;
         xmem.pcn_out <= '0;
         entry_valid <= 1'b0;
      end else if (xmem.WEN) begin
         xmem.wb_memtoreg_out <= xmem.wb_memtoreg_in;
         xmem.wb_regwrite_out <= xmem.wb_regwrite_in;
         xmem.m_branch_out <= xmem.m_branch_in;
         xmem.m_memread_out <= xmem.m_memread_in;
         xmem.m_memwrite_out <= xmem.m_memwrite_in;
         xmem.alu_zero_out <= xmem.alu_zero_in;
         xmem.alu_output_out <= xmem.alu_output_in;
         xmem.adder_result_out <= xmem.adder_result_in;
         xmem.regfile_rdat2_out <= xmem.regfile_rdat2_in;
         xmem.reg_instr_out <= xmem.reg_instr_in;
         xmem.halt_out <= xmem.halt_in;
         xmem.pcn_out <= xmem.pcn_in;
         entry_valid <= 1'b1;
      end
   end

   // decode sets at most one memory direction
   one_mem_dir: assert property (
      @(posedge CLK) disable iff (!nRST) !(xmem.m_memread_out && xmem.m_memwrite_out)
   ) else $error("pl_ex_mem: load and store on one entry");

endmodule

// File: source/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve (
   input  logic                   CLK,
   input  logic                   nRST,
   input  logic                   accept,
   input  pipe_ctrl_pkg::branch_t br_kind,
   input  cpu_types_pkg::word_t   rs_val,
   input  cpu_types_pkg::word_t   rt_val,
   input  cpu_types_pkg::word_t   pcn,
   input  cpu_types_pkg::word_t   imm,
   output logic                   taken,
   output cpu_types_pkg::word_t   target,
   pipereg_ex_mem_if.squash       sq
);
   import pipe_ctrl_pkg::*;

   logic eq;
   logic cond;
   logic squash_q;

   assign eq = (rs_val == rt_val); // own comparator off the alu path

   always_comb begin
      case (br_kind)
         BR_EQ:   cond = eq;
         BR_NE:   cond = !eq;
         BR_JUMP: cond = 1'b1;
         default: cond = 1'b0;
      endcase
   end

   assign target = pcn + (imm << 2);
   assign taken = accept && cond && !squash_q; // a wrong-path branch never redirects

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         squash_q <= 1'b0;
      end else if (accept) begin
         squash_q <= taken;
      end
   end

   assign sq.flush = squash_q;

   // upstream holds the decoded branch while the pipe is stalled
   hold_under_stall: assert property (
      @(posedge CLK) disable iff (!nRST)
         !accept |=> $stable({br_kind, rs_val, rt_val, pcn, imm})
   ) else $error("branch_resolve: branch inputs changed while stalled");

endmodule

// File: source/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
   input  cpu_types_pkg::aluop_t aluop,
   input  cpu_types_pkg::word_t  porta,
   input  cpu_types_pkg::word_t  portb,
   output cpu_types_pkg::word_t  result,
   output logic                  zero
);
   import cpu_types_pkg::*;

   logic [4:0] shamt;

   assign shamt = porta[4:0]; // variable shift amount

   always_comb begin
      case (aluop)
         ALU_ADD:  result = porta + portb;
         ALU_SUB:  result = porta - portb;
         ALU_AND:  result = porta & portb;
         ALU_OR:   result = porta | portb;
         ALU_XOR:  result = porta ^ portb;
         ALU_NOR:  result = ~(porta | portb);
         ALU_SLL:  result = portb << shamt;
         ALU_SRL:  result = portb >> shamt;
         ALU_SLT:  result = word_t'($signed(porta) < $signed(portb));
         ALU_SLTU: result = word_t'(porta < portb);
         default:  result = '0;
      endcase
   end

   assign zero = (result == '0);

   // decode must never hand over an encoding outside the opcode set
   opcode_legal: assert final (
      $isunknown(aluop) ||
      aluop inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                    ALU_NOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_SLTU}
   ) else $error("alu_unit: illegal opcode %0h", aluop);

endmodule

// File: source/pipereg_ex_mem_if.sv
`timescale 1ns/1ps

interface pipereg_ex_mem_if;
   import cpu_types_pkg::*;
   import pipe_ctrl_pkg::*;

   // write-back controls
   memtoreg_t wb_memtoreg_in, wb_memtoreg_out;
   logic      wb_regwrite_in, wb_regwrite_out;

   // memory stage controls
   logic m_branch_in, m_branch_out; // taken branch
   logic m_memread_in, m_memread_out;
   logic m_memwrite_in, m_memwrite_out;

   // execute results and carried operands
   logic     alu_zero_in, alu_zero_out;
   word_t    alu_output_in, alu_output_out;
   word_t    adder_result_in, adder_result_out; // branch target
   word_t    regfile_rdat2_in, regfile_rdat2_out; // store data
   regbits_t reg_instr_in, reg_instr_out; // rd or rt
   logic     halt_in, halt_out;
   word_t    pcn_in, pcn_out;

   logic WEN;
   logic flush;

   modport xmem (
      input  wb_memtoreg_in, wb_regwrite_in, m_branch_in, m_memread_in, m_memwrite_in,
             alu_zero_in, alu_output_in, adder_result_in, regfile_rdat2_in, reg_instr_in,
             halt_in, pcn_in, WEN, flush,
      output wb_memtoreg_out, wb_regwrite_out, m_branch_out, m_memread_out, m_memwrite_out,
             alu_zero_out, alu_output_out, adder_result_out, regfile_rdat2_out,
             reg_instr_out, halt_out, pcn_out
   );

   modport ex (
      output wb_memtoreg_in, wb_regwrite_in, m_branch_in, m_memread_in, m_memwrite_in,
             alu_zero_in, alu_output_in, adder_result_in, regfile_rdat2_in, reg_instr_in,
             halt_in, pcn_in
   );

   modport mem (
      input  wb_memtoreg_out, wb_regwrite_out, m_branch_out, m_memread_out, m_memwrite_out,
             alu_zero_out, alu_output_out, adder_result_out, regfile_rdat2_out,
             reg_instr_out, halt_out, pcn_out,
      output WEN
   );

   modport squash (
      output flush
   );

endinterface

// File: source/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

   // write-back value source
   typedef enum logic [1:0] {
      MTR_ALU  = 2'd0,
      MTR_MEM  = 2'd1,
      MTR_LINK = 2'd2 // pcn as link value
   } memtoreg_t;

   typedef enum logic [1:0] {
      BR_NONE = 2'd0,
      BR_EQ   = 2'd1,
      BR_NE   = 2'd2,
      BR_JUMP = 2'd3
   } branch_t;

   // data memory bus states
   typedef enum logic {
      MEM_IDLE = 1'b0,
      MEM_BUSY = 1'b1
   } mem_state_t;

endpackage

// File: source/cpu_types_pkg.sv
`include "cpu_consts.svh"

package cpu_types_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`REG_W-1:0]  regbits_t;

   // alu opcodes as decoded in ID
   typedef enum logic [3:0] {
      ALU_ADD  = 4'h0,
      ALU_SUB  = 4'h1,
      ALU_AND  = 4'h2,
      ALU_OR   = 4'h3,
      ALU_XOR  = 4'h4,
      ALU_NOR  = 4'h5,
      ALU_SLL  = 4'h6,
      ALU_SRL  = 4'h7,
      ALU_SLT  = 4'h8, // signed compare
      ALU_SLTU = 4'h9  // unsigned compare
   } aluop_t;

endpackage

// File: include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath word width
`define WORD_W 32

// register file address width
`define REG_W 5

// pc value out of reset
`define RESET_PC 32'h0000_0000

`endif
